/* boot_rom.mem */
// boot rom image, one 32-bit hex word per line starting at word 0
00000013
0FF00093
00102023
0000A103
00208133
FE1FF06F
12345678
89ABCDEF

/* testbench/rv_bus_stimulus.txt */
# op W addr data ben | R addr expected | C addr expected (all hex)
# op S swi btn_n (hex) | T cycles (decimal) | L led_g led_r hex0_digit hex1_digit (hex)
L 00 000 0 0
R FFFFC0 00000000
T 1000
R FFFFC0 0000000A
W 000100 11223344 F
W 000104 AABBCCDD F
W 000100 000000EE 1
W 000104 55000000 8
R 000100 112233EE
R 000104 55BBCCDD
W 001200 DEADBEEF F
R 000200 DEADBEEF
R FFFFC8 00000000
R FFFF00 00000000
C FFE000 00000013
C FFE004 0FF00093
C FFE01C 89ABCDEF
C FFE020 00000000
C 000104 55BBCCDD
W FFFFC4 02A5A73C F
L 3C 2A5 7 A
S 2B5 6
T 2
R FFFFC4 000026B5

/* filelist.f */
logic/rv_bus_pkg.sv
logic/io_dev_if.sv
logic/bus_decoder.sv
logic/ram_block.sv
logic/boot_rom.sv
logic/ms_timer.sv
logic/panel_io.sv
logic/rv_bus_top.sv
testbench/rv_bus_assert.sv
testbench/tb_rv_bus.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the bus fabric testbench with Verilator from the project root.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_rv_bus \
  -f filelist.f --Mdir obj_dir -o tb_rv_bus
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/tb_rv_bus > sim.log 2>&1
status=$?
cat sim.log

if grep -q "ERRORS FOUND" sim.log; then
  echo "simulation failed"
  exit 1
fi
if [ $status -ne 0 ] || ! grep -q "NO ERRORS" sim.log; then
  echo "simulation did not finish cleanly"
  exit 1
fi
exit 0

/* testbench/tb_rv_bus.sv */
// run from the project root; reads testbench/rv_bus_stimulus.txt, rom image from boot_rom.mem
`timescale 1ns/1ns

module tb_rv_bus;

  logic                clk;
  logic                rst_n;
  rv_bus_pkg::addr_t   adr;
  logic                rd;
  logic                wr;
  logic [3:0]          ben;
  rv_bus_pkg::word_t   outbus;
  rv_bus_pkg::word_t   codebus;
  rv_bus_pkg::word_t   inbus;
  logic [9:0]          swi_in;
  logic [3:0]          btn_in_n;
  logic [7:0]          led_g;
  logic [9:0]          led_r;
  logic [6:0]          hex0_n;
  logic [6:0]          hex1_n;

  // parsed operations in file order
  logic [7:0]          op_q [$];
  logic [31:0]         a_q [$];
  logic [31:0]         b_q [$];
  logic [31:0]         c_q [$];
  logic [31:0]         d_q [$];

  int unsigned         cycle_limit = 0;
  int unsigned         cycles;

  rv_bus_top #(.clock_freq(100_000), .ram_words(1024)) dut_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .adr      (adr),
    .rd       (rd),
    .wr       (wr),
    .ben      (ben),
    .outbus   (outbus),
    .codebus  (codebus),
    .inbus    (inbus),
    .swi_in   (swi_in),
    .btn_in_n (btn_in_n),
    .led_g    (led_g),
    .led_r    (led_r),
    .hex0_n   (hex0_n),
    .hex1_n   (hex1_n)
  );

  // 10 ns clock
  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // ----------------------------------------
  // watchdog
  // ----------------------------------------
  initial begin
    cycles = 0;
    while (cycle_limit == 0 || cycles <= cycle_limit) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout: run went past %0d cycles without finishing", cycle_limit);
    $display("ERRORS FOUND");
    $fatal(1);
  end

  task automatic value_failed(input string name, input logic [31:0] exp,
                              input logic [31:0] act);
    $display("CHECK FAILED %s expected 0x%h actual 0x%h", name, exp, act);
    $display("ERRORS FOUND");
    $fatal(1);
  endtask

  task automatic run_aborted(input string why);
    $display("%s", why);
    $display("ERRORS FOUND");
    $fatal(1);
  endtask

  // bus quiet with junk on address and data
  task automatic drive_idle();
    rd     = 1'b0;
    wr     = 1'b0;
    ben    = 4'h0;
    adr    = 24'($urandom);
    outbus = $urandom;
  endtask

  // ----------------------------------------
  // stimulus file
  // ----------------------------------------
  // cost is the cycle count the operations will take
  task automatic load_stimulus(output int unsigned cost);
    int               fd;
    int               n;
    logic [7:0]       op;
    logic [31:0]      a;
    logic [31:0]      b;
    logic [31:0]      c;
    logic [31:0]      d;
    logic [8*200-1:0] rest;
    cost = 0;
    fd = $fopen("testbench/rv_bus_stimulus.txt", "r");
    if (fd == 0) run_aborted("could not open the stimulus file testbench/rv_bus_stimulus.txt");
    while ($fscanf(fd, "%s", op) == 1) begin
      a = '0;
      b = '0;
      c = '0;
      d = '0;
      n = 1;
      case (op)
        "#": n = $fgets(rest, fd);
        "W": n = $fscanf(fd, "%h %h %h", a, b, c);
        "R", "C", "S": n = $fscanf(fd, "%h %h", a, b);
        "T": n = $fscanf(fd, "%d", a);
        "L": n = $fscanf(fd, "%h %h %h %h", a, b, c, d);
        default: run_aborted("stimulus file holds an unknown operation");
      endcase
      if (n < 1) run_aborted("stimulus file line is missing its values");
      if (op != "#") begin
        op_q.push_back(op);
        a_q.push_back(a);
        b_q.push_back(b);
        c_q.push_back(c);
        d_q.push_back(d);
        // idle counts its cycles and a board check costs none
        if (op == "T") cost += a;
        else if (op != "L") cost += 1;
      end
    end
    $fclose(fd);
  endtask

  // board outputs against expected digits through the segment table
  task automatic check_board(input logic [31:0] g, input logic [31:0] r,
                             input logic [31:0] d0, input logic [31:0] d1);
    logic [6:0] seg0;
    logic [6:0] seg1;
    seg0 = rv_bus_pkg::seg7_table[d0[3:0]];
    seg1 = rv_bus_pkg::seg7_table[d1[3:0]];
    assert (led_g === g[7:0]) else value_failed("led_g", 32'(g[7:0]), 32'(led_g));
    assert (led_r === r[9:0]) else value_failed("led_r", 32'(r[9:0]), 32'(led_r));
    assert (hex0_n === seg0) else value_failed("hex0_n", 32'(seg0), 32'(hex0_n));
    assert (hex1_n === seg1) else value_failed("hex1_n", 32'(seg1), 32'(hex1_n));
  endtask

  // ----------------------------------------
  // main sequence
  // ----------------------------------------
  initial begin
    int unsigned total;
    logic [7:0]  op;
    logic [31:0] a;
    logic [31:0] b;
    void'($urandom(34903));
    rst_n    = 1'b0;
    swi_in   = '0;
    btn_in_n = 4'hF;
    drive_idle();
    load_stimulus(total);
    cycle_limit = 2 * total + 100;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    // each operation starts on a falling edge and is sampled on the next one
    for (int i = 0; i < op_q.size(); i++) begin
      op = op_q[i];
      a  = a_q[i];
      b  = b_q[i];
      case (op)
        "W": begin
          adr    = a[23:0];
          rd     = 1'b0;
          wr     = 1'b1;
          ben    = c_q[i][3:0];
          outbus = b;
          @(negedge clk);
        end
        "R": begin
          adr    = a[23:0];
          rd     = 1'b1;
          wr     = 1'b0;
          ben    = 4'hF;
          outbus = $urandom;
          @(negedge clk);
          assert (inbus === b) else value_failed("inbus", b, inbus);
        end
        "C": begin
          adr    = a[23:0];
          rd     = 1'b0;
          wr     = 1'b0;
          ben    = 4'h0;
          outbus = $urandom;
          @(negedge clk);
          assert (codebus === b) else value_failed("codebus", b, codebus);
        end
        "S": begin
          swi_in   = a[9:0];
          btn_in_n = b[3:0];
          drive_idle();
          @(negedge clk);
        end
        "T": begin
          drive_idle();
          repeat (a) @(negedge clk);
        end
        default: check_board(a, b, c_q[i], d_q[i]);
      endcase
    end
    drive_idle();
    $display("NO ERRORS");
    $finish;
  end

endmodule

/* testbench/rv_bus_assert.sv */
// decoder strobe checks, active only out of reset; attached to every bus_decoder by bind
`timescale 1ns/1ns

module rv_bus_assert (
  input logic                clk,
  input logic                rst_n,
  input rv_bus_pkg::addr_t   adr,
  input logic                ram_en,
  input logic                rom_en,
  input logic                timer_stb,
  input logic                panel_stb
);

  rv_bus_pkg::cpu_addr_u a_u;

  assign a_u = adr;

  // one target per access at most
  strobe_onehot: assert property (@(posedge clk) disable iff (!rst_n)
    $onehot0({ram_en, rom_en, timer_stb, panel_stb}))
    else $error("more than one of the ram, rom and device strobes is high");

  // device strobes only inside the i/o block
  strobe_in_io_page: assert property (@(posedge clk) disable iff (!rst_n)
    (timer_stb || panel_stb) |-> (a_u.io.page == rv_bus_pkg::IO_PAGE))
    else $error("device strobe high outside the i/o page");

  // ram stays below the rom window
  ram_below_rom: assert property (@(posedge clk) disable iff (!rst_n)
    ram_en |-> (adr < rv_bus_pkg::ROM_BASE))
    else $error("ram enable high at or above the rom base");

endmodule

bind bus_decoder rv_bus_assert assert_i (
  .clk       (clk),
  .rst_n     (rst_n),
  .adr       (adr),
  .ram_en    (ram_en),
  .rom_en    (rom_en),
  .timer_stb (timer_bus.stb),
  .panel_stb (panel_bus.stb)
);

/* logic/rv_bus_top.sv */
// bus fabric without cpu; adr/rd/wr/ben/outbus come from the host, no wait states
`timescale 1ns/1ns

module rv_bus_top #(
  parameter int unsigned clock_freq = 100_000,
  parameter int unsigned ram_words  = 1024
) (
  input  logic                clk,
  input  logic                rst_n,
  // cpu side
  input  rv_bus_pkg::addr_t   adr,
  input  logic                rd,
  input  logic                wr,
  input  logic [3:0]          ben,
  input  rv_bus_pkg::word_t   outbus,
  output rv_bus_pkg::word_t   codebus,
  output rv_bus_pkg::word_t   inbus,
  // board side
  input  logic [9:0]          swi_in,
  input  logic [3:0]          btn_in_n,
  output logic [7:0]          led_g,
  output logic [9:0]          led_r,
  output logic [6:0]          hex0_n,
  output logic [6:0]          hex1_n
);

  logic                ram_en;
  logic                ram_wr;
  logic                rom_en;
  rv_bus_pkg::word_t   ram_rdata;
  rv_bus_pkg::word_t   rom_rdata;

  // one slice per i/o device
  io_dev_if timer_bus ();
  io_dev_if panel_bus ();

  bus_decoder dec_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .adr       (adr),
    .rd        (rd),
    .wr        (wr),
    .outbus    (outbus),
    .ram_rdata (ram_rdata),
    .rom_rdata (rom_rdata),
    .ram_en    (ram_en),
    .ram_wr    (ram_wr),
    .rom_en    (rom_en),
    .codebus   (codebus),
    .inbus     (inbus),
    .timer_bus (timer_bus.host),
    .panel_bus (panel_bus.host)
  );

  // word index wraps modulo ram depth
  ram_block #(.ram_words(ram_words)) ram_i (
    .clk   (clk),
    .en    (ram_en),
    .wr    (ram_wr),
    .ben   (ben),
    .addr  (adr[$clog2(ram_words)+1:2]),
    .wdata (outbus),
    .rdata (ram_rdata)
  );

  boot_rom rom_i (
    .clk   (clk),
    .en    (rom_en),
    .addr  (adr[$clog2(rv_bus_pkg::ROM_WORDS)+1:2]),
    .rdata (rom_rdata)
  );

  ms_timer #(.clock_freq(clock_freq)) tmr_i (
    .clk   (clk),
    .rst_n (rst_n),
    .bus   (timer_bus.device)
  );

  panel_io panel_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .swi_in   (swi_in),
    .btn_in_n (btn_in_n),
    .bus      (panel_bus.device),
    .led_g    (led_g),
    .led_r    (led_r),
    .hex0_n   (hex0_n),
    .hex1_n   (hex1_n)
  );

endmodule

/* logic/panel_io.sv */
// leds and 7-seg driven from one write word; switch/button inputs assumed async, synced here
`timescale 1ns/1ns

module panel_io (
  input  logic         clk,
  input  logic         rst_n,
  input  logic [9:0]   swi_in,
  input  logic [3:0]   btn_in_n,
  io_dev_if.device     bus,
  output logic [7:0]   led_g,
  output logic [9:0]   led_r,
  output logic [6:0]   hex0_n,
  output logic [6:0]   hex1_n
);

  logic [7:0]  hex_q;
  logic [9:0]  swi_s1;
  logic [9:0]  swi_s2;
  logic [3:0]  btn_s1;
  logic [3:0]  btn_s2;
  logic        we;

  // panel sits on the odd register
  assign we = bus.stb & bus.wr & bus.sel;

  // ----------------------------------------
  // output register
  // ----------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      led_g <= '0;
      led_r <= '0;
      hex_q <= '0;
    end else if (we) begin
      led_g <= bus.wdata[7:0];
      hex_q <= bus.wdata[15:8];
      led_r <= bus.wdata[25:16];
    end
  end

  // low digit on hex0, high digit on hex1
  assign hex0_n = rv_bus_pkg::seg7_table[hex_q[3:0]];
  assign hex1_n = rv_bus_pkg::seg7_table[hex_q[7:4]];

  // ----------------------------------------
  // input synchronisers
  // ----------------------------------------
  // buttons idle high
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      swi_s1 <= '0;
      swi_s2 <= '0;
      btn_s1 <= '1;
      btn_s2 <= '1;
    end else begin
      swi_s1 <= swi_in;
      swi_s2 <= swi_s1;
      btn_s1 <= btn_in_n;
      btn_s2 <= btn_s1;
    end
  end

  // pressed button reads as 1
  assign bus.rdata = {18'b0, ~btn_s2, swi_s2};

endmodule

/* logic/ms_timer.sv */
// running millisecond count since reset; clock_freq must be a multiple of 1000
`timescale 1ns/1ns

module ms_timer #(
  parameter int unsigned clock_freq = 100_000
) (
  input  logic       clk,
  input  logic       rst_n,
  io_dev_if.device   bus
);

  // cycles per millisecond
  localparam int unsigned ticks_per_ms = clock_freq / 1000;
  localparam int unsigned presc_w = (ticks_per_ms > 1) ? $clog2(ticks_per_ms) : 1;

  logic [presc_w-1:0]              presc;
  logic [rv_bus_pkg::TIMER_W-1:0]  ms_count;
  logic                            ms_tick;

  // last cycle of each millisecond
  assign ms_tick = (presc == presc_w'(ticks_per_ms - 1));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      presc    <= '0;
      ms_count <= '0;
    end else if (ms_tick) begin
      presc    <= '0;
      ms_count <= ms_count + 1'b1;
    end else begin
      presc <= presc + 1'b1;
    end
  end

  // read only, on the even register of its pair
  assign bus.rdata = bus.sel ? '0 : rv_bus_pkg::word_t'(ms_count);

endmodule

/* logic/boot_rom.sv */
// boot rom image comes from boot_rom.mem in the run directory; missing words read zero
`timescale 1ns/1ns

module boot_rom (
  input  logic                                       clk,
  input  logic                                       en,
  input  logic [$clog2(rv_bus_pkg::ROM_WORDS)-1:0]   addr,
  output rv_bus_pkg::word_t                          rdata
);

  rv_bus_pkg::word_t rom [rv_bus_pkg::ROM_WORDS];

  // clear first so a short image leaves zeros behind it
  initial begin
    for (int i = 0; i < rv_bus_pkg::ROM_WORDS; i++) begin
      rom[i] = '0;
    end
    $readmemh("boot_rom.mem", rom);
  end

  always_ff @(posedge clk) begin
    if (en) rdata <= rom[addr];
  end

endmodule

/* logic/ram_block.sv */
// byte-writable single-port ram, read-before-write, contents undefined after power-up
`timescale 1ns/1ns

module ram_block #(
  parameter int unsigned ram_words = 1024
) (
  input  logic                           clk,
  input  logic                           en,
  input  logic                           wr,
  input  logic [3:0]                     ben,
  input  logic [$clog2(ram_words)-1:0]   addr,
  input  rv_bus_pkg::word_t              wdata,
  output rv_bus_pkg::word_t              rdata
);

  rv_bus_pkg::word_t mem [ram_words];

  // byte lanes written independently
  always_ff @(posedge clk) begin
    if (en && wr) begin
      for (int b = 0; b < 4; b++) begin
        if (ben[b]) begin
          mem[addr][8*b +: 8] <= wdata[8*b +: 8];
        end
      end
    end
  end

  // registered read, old word on a same-address write
  always_ff @(posedge clk) begin
    if (en) begin
      rdata <= mem[addr];
    end
  end

endmodule

/* logic/bus_decoder.sv */
// address decode and bus muxing; memory reads have one cycle latency, i/o reads are same-cycle
`timescale 1ns/1ns

module bus_decoder (
  input  logic                clk,
  input  logic                rst_n,
  input  rv_bus_pkg::addr_t   adr,
  input  logic                rd,
  input  logic                wr,
  input  rv_bus_pkg::word_t   outbus,
  input  rv_bus_pkg::word_t   ram_rdata,
  input  rv_bus_pkg::word_t   rom_rdata,
  output logic                ram_en,
  output logic                ram_wr,
  output logic                rom_en,
  output rv_bus_pkg::word_t   codebus,
  output rv_bus_pkg::word_t   inbus,
  io_dev_if.host              timer_bus,
  io_dev_if.host              panel_bus
);

  // rom window bounds as word indices
  localparam logic [21:0] rom_lo_word = 22'(rv_bus_pkg::ROM_BASE >> 2);
  localparam logic [21:0] rom_hi_word = 22'((rv_bus_pkg::ROM_BASE >> 2) + rv_bus_pkg::ROM_WORDS);

  rv_bus_pkg::cpu_addr_u a_u;
  logic                  io_en;
  logic                  io_act;
  rv_bus_pkg::word_t     io_word;
  // registered source of the word now on the memory outputs
  logic                  ram_q;
  logic                  rom_q;

  assign a_u = adr;

  // ----------------------------------------
  // address decode
  // ----------------------------------------
  // ram below the rom base, ungated so code fetches need no rd
  assign ram_en = (a_u.ram.word_idx < rom_lo_word);
  assign ram_wr = ram_en & wr;
  // lower 2 kB of the rom window
  assign rom_en = (a_u.ram.word_idx >= rom_lo_word) && (a_u.ram.word_idx < rom_hi_word);

  // i/o page, device strobes only on an actual access
  assign io_en  = (a_u.io.page == rv_bus_pkg::IO_PAGE);
  assign io_act = io_en & (rd | wr);

  assign timer_bus.stb   = io_act && (a_u.io.reg_num == rv_bus_pkg::REG_TIMER);
  assign timer_bus.wr    = wr;
  assign timer_bus.sel   = a_u.io.reg_num[0];
  assign timer_bus.wdata = outbus;

  assign panel_bus.stb   = io_act && (a_u.io.reg_num == rv_bus_pkg::REG_PANEL);
  assign panel_bus.wr    = wr;
  assign panel_bus.sel   = a_u.io.reg_num[0];
  assign panel_bus.wdata = outbus;

  // unmapped registers read zero
  assign io_word = timer_bus.stb ? timer_bus.rdata :
                   panel_bus.stb ? panel_bus.rdata :
                   '0;

  // ----------------------------------------
  // bus muxes
  // ----------------------------------------
  // select follows the address by one edge, lining up with memory output
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ram_q <= 1'b0;
      rom_q <= 1'b0;
    end else begin
      ram_q <= ram_en;
      rom_q <= rom_en;
    end
  end

  // code from ram or rom
  assign codebus = rom_q ? rom_rdata : ram_rdata;

  // data from i/o right away, else last cycle's ram word
  assign inbus = io_en ? io_word :
                 ram_q ? ram_rdata :
                 '0;

endmodule

/* logic/io_dev_if.sv */
// one device slice of the i/o bus; no handshake, rdata must be combinational from device state
`timescale 1ns/1ns

interface io_dev_if;

  // strobe is a level held for as long as the address is held
  logic                stb;
  logic                wr;
  // low register number bit, for devices on an odd or even register
  logic                sel;
  rv_bus_pkg::word_t   wdata;
  rv_bus_pkg::word_t   rdata;

  // decoder side
  modport host (output stb, output wr, output sel, output wdata, input rdata);

  // device side
  modport device (input stb, input wr, input sel, input wdata, output rdata);

endinterface

/* logic/rv_bus_pkg.sv */
// shared bus types and map constants; map assumes a 24-bit byte address and 32-bit words
package rv_bus_pkg;

  // cpu byte address and data word
  typedef logic [23:0] addr_t;
  typedef logic [31:0] word_t;

  // one address word, seen as a ram word address or as an i/o register address
  typedef union packed {
    struct packed {
      logic [21:0] word_idx;
      logic [1:0]  byte_off;
    } ram;
    struct packed {
      logic [15:0] page;
      logic [5:0]  reg_num;
      logic [1:0]  byte_off;
    } io;
  } cpu_addr_u;

  // ----------------------------------------
  // memory map
  // ----------------------------------------
  // boot rom window start, nothing at or above is ram
  localparam addr_t ROM_BASE = 24'hFFE000;
  // only the lower 2 kB of the 4 kB window hold words
  localparam int unsigned ROM_WORDS = 512;
  // 256-byte i/o block at 0xFFFF00
  localparam logic [15:0] IO_PAGE = 16'hFFFF;
  // -64 and -60 from the top of the address space
  localparam logic [5:0] REG_TIMER = 6'd48;
  localparam logic [5:0] REG_PANEL = 6'd49;

  // millisecond counter width
  localparam int unsigned TIMER_W = 32;

  // active-low segments, gfedcba, digits 0..F
  localparam logic [6:0] seg7_table [16] = '{
    7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02, 7'h78,
    7'h00, 7'h10, 7'h08, 7'h03, 7'h46, 7'h21, 7'h06, 7'h0E
  };

endpackage
